/* hw/rv_isa_pkg.sv */
package rv_isa_pkg;

	// RV32I major opcodes
	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		BRANCH = 7'b1100011,
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111
	} opcode_e;

	// Branch conditions
	localparam logic [2:0] BEQ  = 3'b000;
	localparam logic [2:0] BNE  = 3'b001;
	localparam logic [2:0] BLT  = 3'b100;
	localparam logic [2:0] BGE  = 3'b101;
	localparam logic [2:0] BLTU = 3'b110;
	localparam logic [2:0] BGEU = 3'b111;

	// Load and store widths
	localparam logic [2:0] F3_B  = 3'b000;
	localparam logic [2:0] F3_H  = 3'b001;
	localparam logic [2:0] F3_W  = 3'b010;
	localparam logic [2:0] F3_BU = 3'b100;
	localparam logic [2:0] F3_HU = 3'b101;

	// ALU functions, shared by OP and OP_IMM
	localparam logic [2:0] F3_ADD  = 3'b000;
	localparam logic [2:0] F3_SLL  = 3'b001;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_SR   = 3'b101;
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;

	// Selects SUB and SRA
	localparam logic [6:0] F7_ALT = 7'b0100000;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		opcode_e    opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		opcode_e     opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		opcode_e    opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		opcode_e    opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm31_12;
		logic [4:0]  rd;
		opcode_e     opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		opcode_e    opcode;
	} j_fmt_t;

	// One instruction word, viewed per format
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} instr_u;

endpackage

/* hw/core_pkg.sv */
package core_pkg;

	localparam int NUM_REGS = 32;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_idx_t;

	// Operations of the execute stage ALU
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_XOR,
		ALU_OR,
		ALU_AND,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_SLT,
		ALU_SLTU
	} alu_op_e;

endpackage

/* hw/decode_if.sv */
`timescale 1ns/100ps

// Decoded instruction held in the decode/execute register
interface decode_if;
	logic                valid;
	core_pkg::word_t     pc;
	rv_isa_pkg::opcode_e opcode;
	logic [2:0]          funct3;
	logic                alt;
	core_pkg::reg_idx_t  rd;
	core_pkg::reg_idx_t  rs1;
	core_pkg::reg_idx_t  rs2;
	core_pkg::word_t     ra;
	core_pkg::word_t     rb;
	core_pkg::word_t     imm;

	modport producer (output valid, pc, opcode, funct3, alt, rd, rs1, rs2, ra, rb, imm);
	modport consumer (input valid, pc, opcode, funct3, alt, rd, rs1, rs2, ra, rb, imm);
endinterface

/* hw/reg_file.sv */
`timescale 1ns/100ps

module reg_file (
	input  logic               clk,
	input  logic               reset,
	input  logic               i_we,
	input  core_pkg::reg_idx_t i_waddr,
	input  core_pkg::word_t    i_wdata,
	input  core_pkg::reg_idx_t i_raddr_a,
	input  core_pkg::reg_idx_t i_raddr_b,
	output core_pkg::word_t    o_rdata_a,
	output core_pkg::word_t    o_rdata_b,
	output core_pkg::word_t    o_view [core_pkg::NUM_REGS]
);
	core_pkg::word_t regs [core_pkg::NUM_REGS];
	logic            wr_live;

	// x0 never takes a write
	assign wr_live = i_we && i_waddr != '0;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < core_pkg::NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_live) begin
			regs[i_waddr] <= i_wdata;
		end
	end

	// Same-cycle write shows through to the readers
	assign o_rdata_a = (wr_live && i_waddr == i_raddr_a) ? i_wdata : regs[i_raddr_a];
	assign o_rdata_b = (wr_live && i_waddr == i_raddr_b) ? i_wdata : regs[i_raddr_b];
	assign o_view    = regs;

endmodule

/* hw/fetch_stage.sv */
`timescale 1ns/100ps

module fetch_stage #(
	parameter core_pkg::word_t RESET_PC = '0
) (
	input  logic            clk,
	input  logic            reset,
	input  logic            i_redirect,
	input  core_pkg::word_t i_target,
	output core_pkg::word_t o_pc_addr,
	output logic            o_pc_rd,
	output logic [3:0]      o_pc_byte_en,
	output core_pkg::word_t o_fetch_pc
);
	core_pkg::word_t pc;
	core_pkg::word_t fetch_pc;

	// Always predicts not-taken
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc <= RESET_PC;
		end else begin
			pc <= i_redirect ? i_target : pc + 32'd4;
		end
	end

	// PC of the word coming back from memory this cycle
	always_ff @(posedge clk) begin
		fetch_pc <= pc;
	end

	assign o_pc_addr    = pc;
	assign o_pc_rd      = 1'b1;
	assign o_pc_byte_en = 4'b1111;
	assign o_fetch_pc   = fetch_pc;

endmodule

/* hw/inst_decoder.sv */
`timescale 1ns/100ps

module inst_decoder (
	input  logic               clk,
	input  logic               reset,
	input  rv_isa_pkg::instr_u i_pc_rddata,
	input  core_pkg::word_t    i_fetch_pc,
	input  logic               i_redirect,
	input  logic               i_wb_we,
	input  core_pkg::reg_idx_t i_wb_rd,
	input  core_pkg::word_t    i_wb_data,
	decode_if.producer         o_bundle,
	output core_pkg::word_t    o_view [core_pkg::NUM_REGS]
);
	core_pkg::word_t imm;
	core_pkg::word_t rdata_a;
	core_pkg::word_t rdata_b;
	logic            known;
	logic            kill_q;

	reg_file reg_file_inst (
		.clk       (clk),
		.reset     (reset),
		.i_we      (i_wb_we),
		.i_waddr   (i_wb_rd),
		.i_wdata   (i_wb_data),
		.i_raddr_a (i_pc_rddata.r.rs1),
		.i_raddr_b (i_pc_rddata.r.rs2),
		.o_rdata_a (rdata_a),
		.o_rdata_b (rdata_b),
		.o_view    (o_view)
	);

	// Immediate per format, sign extended
	always_comb begin
		imm   = '0;
		known = 1'b1;
		case (i_pc_rddata.r.opcode)
			rv_isa_pkg::OP: imm = '0;
			rv_isa_pkg::OP_IMM, rv_isa_pkg::LOAD, rv_isa_pkg::JALR:
				imm = {{20{i_pc_rddata.i.imm[11]}}, i_pc_rddata.i.imm};
			rv_isa_pkg::STORE:
				imm = {{20{i_pc_rddata.s.imm_hi[6]}}, i_pc_rddata.s.imm_hi, i_pc_rddata.s.imm_lo};
			rv_isa_pkg::BRANCH:
				imm = {{19{i_pc_rddata.b.imm12}}, i_pc_rddata.b.imm12, i_pc_rddata.b.imm11,
					i_pc_rddata.b.imm10_5, i_pc_rddata.b.imm4_1, 1'b0};
			rv_isa_pkg::LUI, rv_isa_pkg::AUIPC: imm = {i_pc_rddata.u.imm31_12, 12'b0};
			rv_isa_pkg::JAL:
				imm = {{11{i_pc_rddata.j.imm20}}, i_pc_rddata.j.imm20, i_pc_rddata.j.imm19_12,
					i_pc_rddata.j.imm11, i_pc_rddata.j.imm10_1, 1'b0};
			default: known = 1'b0;
		endcase
	end

	// Second wrong-path word arrives the cycle after a redirect
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			kill_q         <= 1'b1;
			o_bundle.valid <= 1'b0;
		end else begin
			kill_q         <= i_redirect;
			o_bundle.valid <= known && !i_redirect && !kill_q;
		end
	end

	always_ff @(posedge clk) begin
		o_bundle.pc     <= i_fetch_pc;
		o_bundle.opcode <= i_pc_rddata.r.opcode;
		o_bundle.funct3 <= i_pc_rddata.r.funct3;
		o_bundle.alt    <= i_pc_rddata.r.funct7 == rv_isa_pkg::F7_ALT;
		o_bundle.rd     <= i_pc_rddata.r.rd;
		o_bundle.rs1    <= i_pc_rddata.r.rs1;
		o_bundle.rs2    <= i_pc_rddata.r.rs2;
		o_bundle.ra     <= rdata_a;
		o_bundle.rb     <= rdata_b;
		o_bundle.imm    <= imm;
	end

endmodule

/* hw/execute_stage.sv */
`timescale 1ns/100ps

module execute_stage (
	input  logic               clk,
	input  logic               reset,
	decode_if.consumer         i_bundle,
	input  core_pkg::word_t    i_fwd_data,
	output logic               o_redirect,
	output core_pkg::word_t    o_target,
	output core_pkg::word_t    o_ldst_addr,
	output core_pkg::word_t    o_ldst_wrdata,
	output logic               o_ldst_rd,
	output logic               o_ldst_wr,
	output logic [3:0]         o_ldst_byte_en,
	output logic               o_wb_valid,
	output core_pkg::reg_idx_t o_wb_rd,
	output core_pkg::word_t    o_wb_result,
	output logic               o_wb_load,
	output logic [2:0]         o_wb_funct3,
	output logic [1:0]         o_wb_offset
);
	core_pkg::word_t   src_a;
	core_pkg::word_t   src_b;
	core_pkg::word_t   op_a;
	core_pkg::word_t   op_b;
	core_pkg::word_t   alu_out;
	core_pkg::word_t   jalr_sum;
	core_pkg::word_t   st_data;
	core_pkg::alu_op_e alu_op;
	logic [3:0]        lanes;
	logic              take;
	logic              writes_rd;
	logic              is_load;
	logic              is_store;

	// Forward the value being written back this cycle
	assign src_a = (o_wb_valid && o_wb_rd != '0 && o_wb_rd == i_bundle.rs1) ?
		i_fwd_data : i_bundle.ra;
	assign src_b = (o_wb_valid && o_wb_rd != '0 && o_wb_rd == i_bundle.rs2) ?
		i_fwd_data : i_bundle.rb;

	always_comb begin
		alu_op = core_pkg::ALU_ADD;
		if (i_bundle.opcode == rv_isa_pkg::OP || i_bundle.opcode == rv_isa_pkg::OP_IMM) begin
			case (i_bundle.funct3)
				// SUB only exists in the register form
				rv_isa_pkg::F3_ADD: alu_op = (i_bundle.opcode == rv_isa_pkg::OP && i_bundle.alt) ?
					core_pkg::ALU_SUB : core_pkg::ALU_ADD;
				rv_isa_pkg::F3_SLL:  alu_op = core_pkg::ALU_SLL;
				rv_isa_pkg::F3_SLT:  alu_op = core_pkg::ALU_SLT;
				rv_isa_pkg::F3_SLTU: alu_op = core_pkg::ALU_SLTU;
				rv_isa_pkg::F3_XOR:  alu_op = core_pkg::ALU_XOR;
				rv_isa_pkg::F3_SR:   alu_op = i_bundle.alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
				rv_isa_pkg::F3_OR:   alu_op = core_pkg::ALU_OR;
				rv_isa_pkg::F3_AND:  alu_op = core_pkg::ALU_AND;
				default:             alu_op = core_pkg::ALU_ADD;
			endcase
		end
	end

	// Loads, stores and OP_IMM take rs1 plus the immediate
	always_comb begin
		op_a = src_a;
		op_b = i_bundle.imm;
		case (i_bundle.opcode)
			rv_isa_pkg::OP:    op_b = src_b;
			rv_isa_pkg::LUI:   op_a = '0;
			rv_isa_pkg::AUIPC: op_a = i_bundle.pc;
			default: ;
		endcase
	end

	always_comb begin
		case (alu_op)
			core_pkg::ALU_SUB:  alu_out = op_a - op_b;
			core_pkg::ALU_XOR:  alu_out = op_a ^ op_b;
			core_pkg::ALU_OR:   alu_out = op_a | op_b;
			core_pkg::ALU_AND:  alu_out = op_a & op_b;
			core_pkg::ALU_SLL:  alu_out = op_a << op_b[4:0];
			core_pkg::ALU_SRL:  alu_out = op_a >> op_b[4:0];
			core_pkg::ALU_SRA:  alu_out = $signed(op_a) >>> op_b[4:0];
			core_pkg::ALU_SLT:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
			core_pkg::ALU_SLTU: alu_out = {31'b0, op_a < op_b};
			default:            alu_out = op_a + op_b;
		endcase
	end

	always_comb begin
		case (i_bundle.funct3)
			rv_isa_pkg::BEQ:  take = src_a == src_b;
			rv_isa_pkg::BNE:  take = src_a != src_b;
			rv_isa_pkg::BLT:  take = $signed(src_a) < $signed(src_b);
			rv_isa_pkg::BGE:  take = $signed(src_a) >= $signed(src_b);
			rv_isa_pkg::BLTU: take = src_a < src_b;
			rv_isa_pkg::BGEU: take = src_a >= src_b;
			default:          take = 1'b0;
		endcase
	end

	assign jalr_sum = src_a + i_bundle.imm;

	// Redirect on anything that leaves the fall-through path
	always_comb begin
		o_redirect = 1'b0;
		o_target   = i_bundle.pc + i_bundle.imm;
		if (i_bundle.valid) begin
			case (i_bundle.opcode)
				rv_isa_pkg::JAL: o_redirect = 1'b1;
				rv_isa_pkg::JALR: begin
					o_redirect = 1'b1;
					o_target   = {jalr_sum[31:1], 1'b0};
				end
				rv_isa_pkg::BRANCH: o_redirect = take;
				default: ;
			endcase
		end
	end

	assign is_load  = i_bundle.valid && i_bundle.opcode == rv_isa_pkg::LOAD;
	assign is_store = i_bundle.valid && i_bundle.opcode == rv_isa_pkg::STORE;

	// Place data and enables on the addressed byte lanes
	always_comb begin
		case (i_bundle.funct3)
			rv_isa_pkg::F3_B, rv_isa_pkg::F3_BU: begin
				lanes   = 4'b0001;
				st_data = {24'b0, src_b[7:0]};
			end
			rv_isa_pkg::F3_H, rv_isa_pkg::F3_HU: begin
				lanes   = 4'b0011;
				st_data = {16'b0, src_b[15:0]};
			end
			default: begin
				lanes   = 4'b1111;
				st_data = src_b;
			end
		endcase
	end

	assign o_ldst_rd      = is_load;
	assign o_ldst_wr      = is_store;
	assign o_ldst_addr    = (is_load || is_store) ? alu_out : '0;
	assign o_ldst_byte_en = (is_load || is_store) ? lanes << alu_out[1:0] : 4'b0000;
	assign o_ldst_wrdata  = is_store ? st_data << {alu_out[1:0], 3'b000} : '0;

	// Stores and branches write no register
	always_comb begin
		case (i_bundle.opcode)
			rv_isa_pkg::STORE, rv_isa_pkg::BRANCH: writes_rd = 1'b0;
			default:                               writes_rd = 1'b1;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			o_wb_valid <= 1'b0;
		end else begin
			o_wb_valid <= i_bundle.valid && writes_rd;
		end
	end

	always_ff @(posedge clk) begin
		o_wb_rd     <= i_bundle.rd;
		o_wb_load   <= i_bundle.opcode == rv_isa_pkg::LOAD;
		o_wb_funct3 <= i_bundle.funct3;
		o_wb_offset <= alu_out[1:0];
		// Link value for JAL and JALR
		if (i_bundle.opcode == rv_isa_pkg::JAL || i_bundle.opcode == rv_isa_pkg::JALR) begin
			o_wb_result <= i_bundle.pc + 32'd4;
		end else begin
			o_wb_result <= alu_out;
		end
	end

endmodule

/* hw/writeback_stage.sv */
`timescale 1ns/100ps

module writeback_stage (
	input  logic               i_wb_valid,
	input  core_pkg::reg_idx_t i_wb_rd,
	input  core_pkg::word_t    i_wb_result,
	input  logic               i_wb_load,
	input  logic [2:0]         i_wb_funct3,
	input  logic [1:0]         i_wb_offset,
	input  core_pkg::word_t    i_ldst_rddata,
	output logic               o_we,
	output core_pkg::reg_idx_t o_rd,
	output core_pkg::word_t    o_data
);
	logic [7:0]  byte_sel;
	logic [15:0] half_sel;

	// Memory returns the whole word, pick the addressed lanes
	assign byte_sel = i_ldst_rddata[{i_wb_offset, 3'b000} +: 8];
	assign half_sel = i_wb_offset[1] ? i_ldst_rddata[31:16] : i_ldst_rddata[15:0];

	always_comb begin
		o_data = i_wb_result;
		if (i_wb_load) begin
			case (i_wb_funct3)
				rv_isa_pkg::F3_B:  o_data = {{24{byte_sel[7]}}, byte_sel};
				rv_isa_pkg::F3_H:  o_data = {{16{half_sel[15]}}, half_sel};
				rv_isa_pkg::F3_BU: o_data = {24'b0, byte_sel};
				rv_isa_pkg::F3_HU: o_data = {16'b0, half_sel};
				rv_isa_pkg::F3_W:  o_data = i_ldst_rddata;
				default:           o_data = i_ldst_rddata;
			endcase
		end
	end

	// Valid already excludes stores and branches
	assign o_we = i_wb_valid;
	assign o_rd = i_wb_rd;

endmodule

/* hw/rv_core.sv */
`timescale 1ns/100ps

module rv_core #(
	parameter core_pkg::word_t RESET_PC = '0
) (
	input  logic            clk,
	input  logic            reset,
	output core_pkg::word_t o_pc_addr,
	output logic            o_pc_rd,
	input  core_pkg::word_t i_pc_rddata,
	output logic [3:0]      o_pc_byte_en,
	output core_pkg::word_t o_ldst_addr,
	output logic            o_ldst_rd,
	output logic            o_ldst_wr,
	input  core_pkg::word_t i_ldst_rddata,
	output core_pkg::word_t o_ldst_wrdata,
	output logic [3:0]      o_ldst_byte_en,
	output core_pkg::word_t o_reg_view [core_pkg::NUM_REGS]
);
	logic               redirect;
	core_pkg::word_t    target;
	core_pkg::word_t    fetch_pc;
	logic               wb_valid;
	core_pkg::reg_idx_t wb_rd;
	core_pkg::word_t    wb_result;
	logic               wb_load;
	logic [2:0]         wb_funct3;
	logic [1:0]         wb_offset;
	logic               rf_we;
	core_pkg::reg_idx_t rf_rd;
	core_pkg::word_t    rf_data;

	decode_if de_bus ();

	fetch_stage #(
		.RESET_PC (RESET_PC)
	) fetch_stage_inst (
		.clk          (clk),
		.reset        (reset),
		.i_redirect   (redirect),
		.i_target     (target),
		.o_pc_addr    (o_pc_addr),
		.o_pc_rd      (o_pc_rd),
		.o_pc_byte_en (o_pc_byte_en),
		.o_fetch_pc   (fetch_pc)
	);

	inst_decoder inst_decoder_inst (
		.clk         (clk),
		.reset       (reset),
		.i_pc_rddata (i_pc_rddata),
		.i_fetch_pc  (fetch_pc),
		.i_redirect  (redirect),
		.i_wb_we     (rf_we),
		.i_wb_rd     (rf_rd),
		.i_wb_data   (rf_data),
		.o_bundle    (de_bus.producer),
		.o_view      (o_reg_view)
	);

	execute_stage execute_stage_inst (
		.clk            (clk),
		.reset          (reset),
		.i_bundle       (de_bus.consumer),
		.i_fwd_data     (rf_data),
		.o_redirect     (redirect),
		.o_target       (target),
		.o_ldst_addr    (o_ldst_addr),
		.o_ldst_wrdata  (o_ldst_wrdata),
		.o_ldst_rd      (o_ldst_rd),
		.o_ldst_wr      (o_ldst_wr),
		.o_ldst_byte_en (o_ldst_byte_en),
		.o_wb_valid     (wb_valid),
		.o_wb_rd        (wb_rd),
		.o_wb_result    (wb_result),
		.o_wb_load      (wb_load),
		.o_wb_funct3    (wb_funct3),
		.o_wb_offset    (wb_offset)
	);

	writeback_stage writeback_stage_inst (
		.i_wb_valid    (wb_valid),
		.i_wb_rd       (wb_rd),
		.i_wb_result   (wb_result),
		.i_wb_load     (wb_load),
		.i_wb_funct3   (wb_funct3),
		.i_wb_offset   (wb_offset),
		.i_ldst_rddata (i_ldst_rddata),
		.o_we          (rf_we),
		.o_rd          (rf_rd),
		.o_data        (rf_data)
	);

endmodule

/* verification/rv_core_tb.sv */
`timescale 1ns/100ps

module rv_core_tb;

	logic            clk;
	logic            reset;
	core_pkg::word_t i_pc_rddata;
	core_pkg::word_t i_ldst_rddata;
	core_pkg::word_t o_pc_addr;
	logic            o_pc_rd;
	logic [3:0]      o_pc_byte_en;
	core_pkg::word_t o_ldst_addr;
	logic            o_ldst_rd;
	logic            o_ldst_wr;
	core_pkg::word_t o_ldst_wrdata;
	logic [3:0]      o_ldst_byte_en;
	core_pkg::word_t o_reg_view [core_pkg::NUM_REGS];

	core_pkg::word_t imem [64];
	core_pkg::word_t dmem [256];
	core_pkg::word_t exp_reg [core_pkg::NUM_REGS];
	core_pkg::word_t exp_st_addr [$];
	core_pkg::word_t exp_st_data [$];
	logic [3:0]      exp_st_be [$];
	int              st_seen;
	int              budget;
	logic            loaded;
	core_pkg::word_t fetch_addr;
	logic [7:0]      ld_idx;

	rv_core #(
		.RESET_PC (32'h0000_0000)
	) rv_core_inst (
		.clk            (clk),
		.reset          (reset),
		.o_pc_addr      (o_pc_addr),
		.o_pc_rd        (o_pc_rd),
		.i_pc_rddata    (i_pc_rddata),
		.o_pc_byte_en   (o_pc_byte_en),
		.o_ldst_addr    (o_ldst_addr),
		.o_ldst_rd      (o_ldst_rd),
		.o_ldst_wr      (o_ldst_wr),
		.i_ldst_rddata  (i_ldst_rddata),
		.o_ldst_wrdata  (o_ldst_wrdata),
		.o_ldst_byte_en (o_ldst_byte_en),
		.o_reg_view     (o_reg_view)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic stop_with_failure();
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input core_pkg::word_t expected,
		input core_pkg::word_t actual);
		if (expected !== actual) begin
			$display("Error at %0t: %s expected %h got %h", $time, name, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (expected !== actual) begin
			$display("Error at %0t: %s expected %b got %b", $time, name, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic check_byte_en(input string name, input logic [3:0] expected,
		input logic [3:0] actual);
		if (expected !== actual) begin
			$display("Error at %0t: %s expected %h got %h", $time, name, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic check_store(input core_pkg::word_t addr, input core_pkg::word_t data,
		input logic [3:0] be);
		string names;
		names = "o_ldst_addr/o_ldst_wrdata/o_ldst_byte_en";
		if (st_seen >= exp_st_addr.size()) begin
			$display("Store to %h appeared after all expected stores were seen", addr);
			stop_with_failure();
		end
		if (addr !== exp_st_addr[st_seen] || data !== exp_st_data[st_seen] ||
			be !== exp_st_be[st_seen]) begin
			$display("Error at %0t: %s expected %h/%h/%h got %h/%h/%h",
				$time, names, exp_st_addr[st_seen], exp_st_data[st_seen], exp_st_be[st_seen],
				addr, data, be);
			stop_with_failure();
		end
		st_seen++;
	endtask

	task automatic read_stimulus();
		int              fd;
		int              code;
		int              n_prog;
		int              idx;
		logic [63:0]     tag;
		logic [1023:0]   line;
		core_pkg::word_t a;
		core_pkg::word_t d;
		logic [3:0]      b;
		n_prog = 0;
		fd = $fopen("verification/core_stimulus.dat", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file");
			stop_with_failure();
		end
		while (!$feof(fd)) begin
			code = $fscanf(fd, "%s", tag);
			if (code != 1) break;
			if (tag == "#") begin
				code = $fgets(line, fd);
			end else if (tag == "P") begin
				code = $fscanf(fd, "%h", d);
				imem[n_prog] = d;
				n_prog++;
			end else if (tag == "S") begin
				code = $fscanf(fd, "%h %h %h", a, d, b);
				exp_st_addr.push_back(a);
				exp_st_data.push_back(d);
				exp_st_be.push_back(b);
			end else if (tag == "R") begin
				code = $fscanf(fd, "%d %h", idx, d);
				exp_reg[idx[4:0]] = d;
			end else if (tag == "C") begin
				code = $fscanf(fd, "%d", budget);
			end
		end
		$fclose(fd);
	endtask

	// Both memories answer one cycle after the request
	always @(posedge clk) begin
		#0.5;
		// Fetch is always a full-word read
		check_bit("o_pc_rd", 1'b1, o_pc_rd);
		check_byte_en("o_pc_byte_en", 4'b1111, o_pc_byte_en);
		if (reset) begin
			check_bit("o_ldst_rd", 1'b0, o_ldst_rd);
			check_bit("o_ldst_wr", 1'b0, o_ldst_wr);
		end
		i_pc_rddata   = imem[fetch_addr[7:2]];
		fetch_addr    = o_pc_addr;
		i_ldst_rddata = dmem[ld_idx];
		if (o_ldst_wr) begin
			check_store(o_ldst_addr, o_ldst_wrdata, o_ldst_byte_en);
			for (int i = 0; i < 4; i++) begin
				if (o_ldst_byte_en[i]) dmem[o_ldst_addr[9:2]][8*i +: 8] = o_ldst_wrdata[8*i +: 8];
			end
		end
		if (o_ldst_rd) ld_idx = o_ldst_addr[9:2];
	end

	initial begin
		wait (loaded);
		#((budget + 20) * 4);
		$display("Watchdog expired after %0d cycles without the run ending", budget + 20);
		stop_with_failure();
	end

	initial begin
		reset         = 1'b1;
		i_pc_rddata   = '0;
		i_ldst_rddata = '0;
		fetch_addr    = '0;
		ld_idx        = '0;
		st_seen       = 0;
		budget        = 0;
		loaded        = 1'b0;
		for (int i = 0; i < 64; i++) imem[i] = '0;
		for (int i = 0; i < 256; i++) dmem[i] = '0;
		for (int i = 0; i < core_pkg::NUM_REGS; i++) exp_reg[i] = '0;
		read_stimulus();
		loaded = 1'b1;
		repeat (3) @(posedge clk);
		#0.5 reset = 1'b0;
		repeat (budget) @(posedge clk);
		#1;
		for (int i = 0; i < core_pkg::NUM_REGS; i++) begin
			check_word($sformatf("o_reg_view[%0d]", i), exp_reg[i], o_reg_view[i]);
		end
		if (st_seen != exp_st_addr.size()) begin
			$display("Only %0d of %0d expected stores appeared", st_seen, exp_st_addr.size());
			stop_with_failure();
		end else begin
			$display("TEST OK");
			$finish;
		end
	end

endmodule

/* verification/core_stimulus.dat */
# P word | S addr data byte_en | R reg value | C cycles
# ALU, upper immediates, stores and loads
P 00500093
P ffd00113
P 002081b3
P 40208233
P 401152b3
P 00112333
P 001133b3
P 12345437
P 00001497
P 67844513
P 04a02023
P 042002a3
P 04a01523
P 04500583
P 04504603
P 04401683
P 04405703
P 04802783
# Branches, each taken then not taken, x17 only in dead slots
P 00108663
P 00188893
P 06102023
P 00208463
P 00180813
P 00209463
P 00188893
P 00109463
P 00180813
P 00114463
P 00188893
P 0020c463
P 00180813
P 0020d463
P 00188893
P 00115463
P 00180813
P 0020e463
P 00188893
P 00116463
P 00180813
P 00117463
P 00188893
P 0020f463
P 00180813
# JAL, JALR with odd target, write to x0, then spin
P 0080096f
P 00188893
P 011909e7
P 00188893
P 00188893
P 00700013
P 00100a33
P 0000006f
S 00000040 12345678 f
S 00000045 0000fd00 2
S 0000004a 56780000 c
R 0 00000000
R 1 00000005
R 2 fffffffd
R 3 00000002
R 4 00000008
R 5 ffffffff
R 6 00000001
R 8 12345000
R 9 00001020
R 10 12345678
R 11 fffffffd
R 12 000000fd
R 13 fffffd00
R 14 0000fd00
R 15 56780000
R 16 00000006
R 17 00000000
R 18 000000b0
R 19 000000b8
R 20 00000005
C 100

/* vlog.f */
hw/rv_isa_pkg.sv
hw/core_pkg.sv
hw/decode_if.sv
hw/reg_file.sv
hw/fetch_stage.sv
hw/inst_decoder.sv
hw/execute_stage.sv
hw/writeback_stage.sv
hw/rv_core.sv
verification/rv_core_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f vlog.f --top-module rv_core_tb -o rv_core_sim > build.log 2>&1 &&
./obj_dir/rv_core_sim > sim.log 2>&1
grep -q "^TEST OK$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
